//--- include/chan_sum_defines.svh
`ifndef CHAN_SUM_DEFINES_SVH
`define CHAN_SUM_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Channel accumulator sizing
////////////////////////////////////////////////////////////////////////////

// Width of one partial-result pixel
`define CS_PIXEL_WIDTH 16

// Channels per frame, power of two only
`define CS_CHANNELS 4

// Pixels in one channel plane
`define CS_PLANE_PIXELS 8

// One extra bit per adder level keeps the sum exact
`define CS_SUM_WIDTH (`CS_PIXEL_WIDTH + $clog2(`CS_CHANNELS))

`endif

//--- hw/chan_sum_pkg.sv
package chan_sum_pkg;

`include "chan_sum_defines.svh"

  // Fixed-point pixel and widened channel sum
  typedef logic signed [`CS_PIXEL_WIDTH-1:0] pixel_t;
  typedef logic signed [`CS_SUM_WIDTH-1:0]   sum_t;

  // pix[k] holds the same position from k planes earlier
  typedef struct packed {
    pixel_t [`CS_CHANNELS-1:0] pix;
  } tap_bundle_t;

  // One output beat of the adder tree
  typedef struct packed {
    logic valid;
    logic last;
    sum_t sum;
  } sum_beat_t;

endpackage

//--- hw/channel_sequencer.sv
`timescale 1ns/100ps
`include "chan_sum_defines.svh"

module channel_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic valid_in,
  output logic issue,
  output logic issue_last
);

  localparam int PIX_CNT_W  = (`CS_PLANE_PIXELS > 1) ? $clog2(`CS_PLANE_PIXELS) : 1;
  localparam int CHAN_CNT_W = (`CS_CHANNELS > 1) ? $clog2(`CS_CHANNELS) : 1;

  localparam logic [PIX_CNT_W-1:0]  PIX_LAST  = PIX_CNT_W'(`CS_PLANE_PIXELS - 1);
  localparam logic [CHAN_CNT_W-1:0] CHAN_LAST = CHAN_CNT_W'(`CS_CHANNELS - 1);

  logic [PIX_CNT_W-1:0]  pix_cnt;
  logic [CHAN_CNT_W-1:0] chan_cnt;
  logic                  plane_end;

  assign plane_end = (pix_cnt == PIX_LAST);

  //////////////////////////////////////////////////////////////////////////
  // Position and channel counters, stepping on valid beats only
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_cnt  <= '0;
      chan_cnt <= '0;
    end else if (valid_in) begin
      if (plane_end) begin
        pix_cnt <= '0;
        if (chan_cnt == CHAN_LAST) begin
          chan_cnt <= '0;
        end else begin
          chan_cnt <= chan_cnt + 1'b1;
        end
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  // Last plane of the frame drives the tree
  assign issue      = valid_in && (chan_cnt == CHAN_LAST);
  assign issue_last = issue && plane_end;

  //////////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////////

  a_pix_cnt_range: assert property (
    @(posedge clk) disable iff (reset) pix_cnt <= PIX_LAST
  );

  a_chan_cnt_range: assert property (
    @(posedge clk) disable iff (reset) chan_cnt <= CHAN_LAST
  );

  // Frame end comes with issue and hands over to channel 0, position 0
  a_frame_wrap: assert property (
    @(posedge clk) disable iff (reset)
      issue_last |-> issue ##1 (pix_cnt == '0 && chan_cnt == '0)
  );

endmodule

//--- hw/plane_delay_line.sv
`timescale 1ns/100ps
`include "chan_sum_defines.svh"

module plane_delay_line (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     valid_in,
  input  chan_sum_pkg::pixel_t     pxl_in,
  output chan_sum_pkg::tap_bundle_t taps
);

  import chan_sum_pkg::*;

  // One line per earlier plane
  localparam int LINES = `CS_CHANNELS - 1;
  localparam int DEPTH = `CS_PLANE_PIXELS;

  // Live pixel is tap 0
  assign taps.pix[0] = pxl_in;

  //////////////////////////////////////////////////////////////////////////
  // Chained plane-length shift registers
  //////////////////////////////////////////////////////////////////////////

  genvar l;
  generate
    for (l = 0; l < LINES; l++) begin : g_line
      pixel_t sr [DEPTH];

      // Gaps in the stream hold every stage
      always_ff @(posedge clk) begin
        if (reset) begin
          for (int p = 0; p < DEPTH; p++) begin
            sr[p] <= '0;
          end
        end else if (valid_in) begin
          sr[0] <= taps.pix[l];
          for (int p = 1; p < DEPTH; p++) begin
            sr[p] <= sr[p-1];
          end
        end
      end

      // Oldest entry is exactly one plane behind the line input
      assign taps.pix[l+1] = sr[DEPTH-1];
    end
  endgenerate

endmodule

//--- hw/channel_adder_tree.sv
`timescale 1ns/100ps
`include "chan_sum_defines.svh"

module channel_adder_tree (
  input  logic                      clk,
  input  logic                      reset,
  input  chan_sum_pkg::tap_bundle_t taps,
  input  logic                      issue,
  input  logic                      issue_last,
  output chan_sum_pkg::sum_beat_t   result
);

  import chan_sum_pkg::*;

  localparam int LEVELS = $clog2(`CS_CHANNELS);

  if ((1 << LEVELS) != `CS_CHANNELS) begin : g_bad_channels
    $error("CS_CHANNELS must be a power of two");
  end

  //////////////////////////////////////////////////////////////////////////
  // Tree levels, level 0 is the unregistered tap input
  //////////////////////////////////////////////////////////////////////////

  genvar lv;
  genvar j;
  generate
    for (lv = 0; lv <= LEVELS; lv++) begin : g_lvl
      localparam int W = `CS_PIXEL_WIDTH + lv;
      localparam int N = `CS_CHANNELS >> lv;

      logic signed [W-1:0] val [N];
      logic                vld;
      logic                lst;

      if (lv == 0) begin : g_in
        for (j = 0; j < N; j++) begin : g_tap
          assign val[j] = taps.pix[j];
        end
        assign vld = issue;
        assign lst = issue_last;
      end else begin : g_add
        // Pair sums grow by one bit per level
        always_ff @(posedge clk) begin
          if (g_lvl[lv-1].vld) begin
            for (int k = 0; k < N; k++) begin
              val[k] <= W'(g_lvl[lv-1].val[2*k]) + W'(g_lvl[lv-1].val[2*k+1]);
            end
          end
        end

        // Flags follow the data one level per cycle
        always_ff @(posedge clk) begin
          if (reset) begin
            vld <= 1'b0;
            lst <= 1'b0;
          end else begin
            vld <= g_lvl[lv-1].vld;
            lst <= g_lvl[lv-1].lst;
          end
        end

        a_last_needs_valid: assert property (
          @(posedge clk) disable iff (reset) lst |-> vld
        );
      end
    end
  endgenerate

  assign result.valid = g_lvl[LEVELS].vld;
  assign result.last  = g_lvl[LEVELS].lst;
  assign result.sum   = sum_t'(g_lvl[LEVELS].val[0]);

endmodule

//--- hw/chan_sum_top.sv
`timescale 1ns/100ps

module chan_sum_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 valid_in,
  input  chan_sum_pkg::pixel_t pxl_in,
  output logic                 valid_out,
  output logic                 last_out,
  output chan_sum_pkg::sum_t   sum_out
);

  import chan_sum_pkg::*;

  logic        issue;
  logic        issue_last;
  tap_bundle_t taps;
  sum_beat_t   result;

  channel_sequencer u_sequencer (
    .clk        (clk),
    .reset      (reset),
    .valid_in   (valid_in),
    .issue      (issue),
    .issue_last (issue_last)
  );

  plane_delay_line u_delay_line (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .pxl_in   (pxl_in),
    .taps     (taps)
  );

  channel_adder_tree u_adder_tree (
    .clk        (clk),
    .reset      (reset),
    .taps       (taps),
    .issue      (issue),
    .issue_last (issue_last),
    .result     (result)
  );

  // Output beat split into plain ports
  assign valid_out = result.valid;
  assign last_out  = result.last;
  assign sum_out   = result.sum;

endmodule

//--- verification/chan_sum_tb.sv
`timescale 1ns/100ps
`include "chan_sum_defines.svh"

module chan_sum_tb;

  import chan_sum_pkg::*;

  localparam int LATENCY        = $clog2(`CS_CHANNELS);
  localparam int FRAME_BEATS    = `CS_CHANNELS * `CS_PLANE_PIXELS;
  localparam int FRAMES_RANDOM  = 6;
  localparam int FRAMES_EXTREME = 2;
  localparam int FRAMES_GAPS    = 6;
  localparam int FRAMES         = FRAMES_RANDOM + FRAMES_EXTREME + FRAMES_GAPS;
  localparam int TOTAL_BEATS    = FRAMES * FRAME_BEATS;
  // Valid rate of about 3/4 becomes the 4/3 factor
  localparam int CYCLE_LIMIT    = (2 * TOTAL_BEATS * 4) / 3 + 50;

  localparam int KIND_RANDOM = 0;
  localparam int KIND_MAX    = 1;
  localparam int KIND_MIN    = 2;

  localparam pixel_t PIX_MAX = {1'b0, {(`CS_PIXEL_WIDTH-1){1'b1}}};
  localparam pixel_t PIX_MIN = {1'b1, {(`CS_PIXEL_WIDTH-1){1'b0}}};

  // One expected output beat
  typedef struct packed {
    sum_t sum;
    logic last;
    int   due;
  } expect_t;

  logic   clk;
  logic   reset;
  logic   valid_in;
  pixel_t pxl_in;
  logic   valid_out;
  logic   last_out;
  sum_t   sum_out;

  logic [31:0] rng_state;
  int          cyc;
  int          m_pos;
  int          m_chan;
  pixel_t      plane_mem [`CS_CHANNELS][`CS_PLANE_PIXELS];
  expect_t     exp_q [$];

  chan_sum_top chan_sum_top_inst (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .pxl_in    (pxl_in),
    .valid_out (valid_out),
    .last_out  (last_out),
    .sum_out   (sum_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random source and error handling
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic stop_on_error();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_sum(input string name, input sum_t got, input sum_t exp);
    if (got !== exp) begin
      $display("ERROR: %s got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR: %s got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERROR: %s arrival cycle 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and output monitor
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_accept(input pixel_t p);
    int      acc;
    int      c;
    expect_t e;
    if (m_chan == `CS_CHANNELS - 1) begin
      // Exact channel sum for this position
      acc = int'(p);
      for (c = 0; c < `CS_CHANNELS - 1; c++) begin
        acc += int'(plane_mem[c][m_pos]);
      end
      e.sum  = sum_t'(acc);
      e.last = (m_pos == `CS_PLANE_PIXELS - 1);
      e.due  = cyc + LATENCY;
      exp_q.push_back(e);
    end else begin
      plane_mem[m_chan][m_pos] = p;
    end
    if (m_pos == `CS_PLANE_PIXELS - 1) begin
      m_pos  = 0;
      m_chan = (m_chan + 1) % `CS_CHANNELS;
    end else begin
      m_pos++;
    end
  endtask

  task automatic watch_outputs();
    expect_t e;
    if (valid_out !== 1'b0 && valid_out !== 1'b1) begin
      $display("valid_out is unknown at cycle %0d", cyc);
      stop_on_error();
    end else if (valid_out) begin
      if (exp_q.size() == 0) begin
        $display("Output beat at cycle %0d with no sum expected", cyc);
        stop_on_error();
      end else begin
        e = exp_q.pop_front();
        check_latency("valid_out", cyc, e.due);
        check_sum("sum_out", sum_out, e.sum);
        check_last("last_out", last_out, e.last);
      end
    end
    if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
      $display("Output beat due at cycle %0d never arrived", exp_q[0].due);
      stop_on_error();
    end
  endtask

  // Outputs are checked at the falling edge before the inputs change
  task automatic drive_cycle(input logic v, input pixel_t p);
    @(negedge clk);
    cyc++;
    if (cyc > CYCLE_LIMIT) begin
      $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_on_error();
    end
    watch_outputs();
    valid_in = v;
    pxl_in   = p;
    if (v) begin
      model_accept(p);
    end
  endtask

  task automatic send_frame(input int kind, input bit gaps);
    logic [31:0] r;
    pixel_t      p;
    int          i;
    for (i = 0; i < FRAME_BEATS; i++) begin
      if (gaps) begin
        // About one idle cycle in four with junk data on the bus
        next_random(r);
        while (r[1:0] == 2'b00) begin
          drive_cycle(1'b0, pixel_t'(r[31:16]));
          next_random(r);
        end
      end
      next_random(r);
      case (kind)
        KIND_MAX: p = PIX_MAX;
        KIND_MIN: p = PIX_MIN;
        default:  p = pixel_t'(r[15:0]);
      endcase
      drive_cycle(1'b1, p);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset      = 1'b1;
    valid_in   = 1'b0;
    pxl_in     = '0;
    rng_state  = 32'd50;
    cyc        = 0;
    m_pos      = 0;
    m_chan     = 0;

    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Back-to-back frames so the last plane issues every cycle
    repeat (FRAMES_RANDOM) send_frame(KIND_RANDOM, 1'b0);

    // Full-scale sums
    send_frame(KIND_MAX, 1'b0);
    send_frame(KIND_MIN, 1'b0);

    // Gaps inside and between planes
    repeat (FRAMES_GAPS) send_frame(KIND_RANDOM, 1'b1);

    repeat (LATENCY + 4) drive_cycle(1'b0, '0);

    if (exp_q.size() != 0) begin
      $display("%0d expected sums were never produced", exp_q.size());
      stop_on_error();
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

//--- chan_sum_top.f
+incdir+include
hw/chan_sum_pkg.sv
hw/channel_sequencer.sv
hw/plane_delay_line.sv
hw/channel_adder_tree.sv
hw/chan_sum_top.sv
verification/chan_sum_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the channel accumulator testbench with Verilator.
# The exit status is the simulator's own: nonzero when the run fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
  --top-module chan_sum_tb \
  -f chan_sum_top.f \
  -o chan_sum_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/chan_sum_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

exit 0
